// ==== files.f ====
+incdir+tests
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
tests/tb_mips_core.sv

// ==== src/decode_stage.sv ====
/*
 * Instruction decode.
 * Main controller, register file with write-through to the read ports,
 * sign extension, beq/bne compare and branch or jump target. Also
 * detects the load-use hazard against its own ID/EX output and inserts
 * a bubble into ID/EX while stalling.
 */
module decode_stage import mips_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  if_id_t  if_id,
	input  wb_bus_t wb,
	output logic    stall,
	output logic    redirect,
	output word_t   target,
	output id_ex_t  id_ex
);

	opcode_t   opcode;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     imm;
	word_t     rs_data;
	word_t     rt_data;
	word_t     regs [32];
	ex_ctrl_t  ex_ctrl;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t  wb_ctrl;
	logic      reg_dst_rd;
	logic      branch;
	logic      branch_ne;
	logic      jump;
	logic      taken;
	word_t     branch_target;
	word_t     jump_target;

	assign opcode = opcode_t'(if_id.instr[31:26]);
	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];
	assign rd = if_id.instr[15:11];
	assign imm = {{16{if_id.instr[15]}}, if_id.instr[15:0]};

	// controller
	always_comb begin
		ex_ctrl.alu_class = CLASS_ADD;
		ex_ctrl.alu_src = 1'b0;
		ex_ctrl.funct = funct_t'(if_id.instr[5:0]);
		ex_ctrl.shamt = if_id.instr[10:6];
		mem_ctrl = '0;
		wb_ctrl = '0;
		reg_dst_rd = 1'b0;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				ex_ctrl.alu_class = CLASS_FUNCT;
				wb_ctrl.reg_write = 1'b1;
				reg_dst_rd = 1'b1;
			end
			OP_ADDI: begin
				ex_ctrl.alu_src = 1'b1;
				wb_ctrl.reg_write = 1'b1;
			end
			OP_LW: begin
				ex_ctrl.alu_src = 1'b1;
				mem_ctrl.mem_read = 1'b1;
				wb_ctrl.reg_write = 1'b1;
				wb_ctrl.mem_to_reg = 1'b1;
			end
			OP_SW: begin
				ex_ctrl.alu_src = 1'b1;
				mem_ctrl.mem_write = 1'b1;
			end
			OP_BEQ: begin
				ex_ctrl.alu_class = CLASS_SUB;
				branch = 1'b1;
			end
			OP_BNE: begin
				ex_ctrl.alu_class = CLASS_SUB;
				branch = 1'b1;
				branch_ne = 1'b1;
			end
			OP_J: jump = 1'b1;
			default: ;
		endcase
	end

	// register file, written at the clock edge ending WB
	always_ff @(posedge clk) begin
		if (wb.write_en)
			regs[wb.dest] <= wb.data;
	end

	// same-cycle writeback passes straight through to the reads
	assign rs_data = (rs == '0) ? '0 : (wb.write_en && wb.dest == rs) ? wb.data : regs[rs];
	assign rt_data = (rt == '0) ? '0 : (wb.write_en && wb.dest == rt) ? wb.data : regs[rt];

	// load in EX feeding this instruction
	assign stall = if_id.valid && id_ex.mem_ctrl.mem_read && id_ex.dest != '0 &&
		(id_ex.dest == rs || id_ex.dest == rt);

	// branch compare uses unforwarded register values
	assign taken = branch && (branch_ne ? (rs_data != rt_data) : (rs_data == rt_data));
	assign branch_target = if_id.pc_plus4 + {imm[29:0], 2'b00};
	assign jump_target = {if_id.pc_plus4[31:28], if_id.instr[25:0], 2'b00};

	assign redirect = if_id.valid && !stall && (jump || taken);
	assign target = jump ? jump_target : branch_target;

	// ID/EX
	always_ff @(posedge clk) begin
		id_ex.ex_ctrl <= ex_ctrl;
		id_ex.rs <= rs;
		id_ex.rt <= rt;
		id_ex.dest <= reg_dst_rd ? rd : rt;
		id_ex.rs_data <= rs_data;
		id_ex.rt_data <= rt_data;
		id_ex.imm <= imm;
		if (reset || stall || !if_id.valid) begin
			id_ex.mem_ctrl <= '0;
			id_ex.wb_ctrl <= '0;
		end else begin
			id_ex.mem_ctrl <= mem_ctrl;
			id_ex.wb_ctrl <= wb_ctrl;
		end
	end

endmodule

// ==== src/execute_stage.sv ====
/*
 * Execute.
 * Picks each ALU operand from the MEM stage, the WB stage or the
 * register read, in that order of priority, maps the decode class and
 * funct to an ALU operation and registers the result into EX/MEM.
 * The MEM-stage forward comes from this stage's own EX/MEM output.
 */
module execute_stage import mips_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  id_ex_t  id_ex,
	input  wb_bus_t wb,
	output ex_mem_t ex_mem
);

	word_t   operand_a;
	word_t   operand_b;
	word_t   rt_value;
	word_t   alu_result;
	alu_op_t alu_op;

	// newest producer wins, register 0 is never forwarded
	function automatic word_t forward(
		input reg_addr_t src,
		input word_t     reg_data,
		input ex_mem_t   mem_stage,
		input wb_bus_t   wb_stage
	);
		if (src != '0 && mem_stage.wb_ctrl.reg_write && mem_stage.dest == src)
			return mem_stage.alu_result;
		if (src != '0 && wb_stage.write_en && wb_stage.dest == src)
			return wb_stage.data;
		return reg_data;
	endfunction

	assign operand_a = forward(id_ex.rs, id_ex.rs_data, ex_mem, wb);
	assign rt_value = forward(id_ex.rt, id_ex.rt_data, ex_mem, wb);
	assign operand_b = id_ex.ex_ctrl.alu_src ? id_ex.imm : rt_value;

	// ALU controller
	always_comb begin
		case (id_ex.ex_ctrl.alu_class)
			CLASS_SUB: alu_op = ALU_SUB;
			CLASS_FUNCT: begin
				case (id_ex.ex_ctrl.funct)
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLL: alu_op = ALU_SLL;
					default: alu_op = ALU_ADD;
				endcase
			end
			default: alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_SUB: alu_result = operand_a - operand_b;
			ALU_AND: alu_result = operand_a & operand_b;
			ALU_OR: alu_result = operand_a | operand_b;
			ALU_SLT: alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			// sll shifts rt, which sits on operand b
			ALU_SLL: alu_result = operand_b << id_ex.ex_ctrl.shamt;
			default: alu_result = operand_a + operand_b;
		endcase
	end

	// EX/MEM
	always_ff @(posedge clk) begin
		ex_mem.dest <= id_ex.dest;
		ex_mem.alu_result <= alu_result;
		ex_mem.store_data <= rt_value;
		if (reset) begin
			ex_mem.mem_ctrl <= '0;
			ex_mem.wb_ctrl <= '0;
		end else begin
			ex_mem.mem_ctrl <= id_ex.mem_ctrl;
			ex_mem.wb_ctrl <= id_ex.wb_ctrl;
		end
	end

endmodule

// ==== src/fetch_stage.sv ====
/*
 * Instruction fetch.
 * Holds the PC, the instruction memory and the IF/ID register.
 * The memory is written from the load port while reset is high and
 * read combinationally at the PC. Stall holds PC and IF/ID; a redirect
 * from decode loads the target and turns IF/ID into a bubble.
 */
module fetch_stage import mips_pkg::*; #(
	parameter int IMEM_ADDR_BITS = 6
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   load,
	input  logic   stall,
	input  logic   redirect,
	input  word_t  load_addr,
	input  word_t  load_data,
	input  word_t  target,
	output if_id_t if_id
);

	word_t pc;
	word_t pc_plus4;
	word_t instr;
	word_t imem [2**IMEM_ADDR_BITS];

	assign pc_plus4 = pc + 32'd4;

	// word indexed, low two address bits ignored
	assign instr = imem[pc[IMEM_ADDR_BITS+1:2]];

	always_ff @(posedge clk) begin
		if (reset && load)
			imem[load_addr[IMEM_ADDR_BITS+1:2]] <= load_data;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (redirect)
			pc <= target;
		else if (!stall)
			pc <= pc_plus4;
	end

	// IF/ID, redirect never comes together with stall
	always_ff @(posedge clk) begin
		if (reset || redirect)
			if_id.valid <= 1'b0;
		else if (!stall)
			if_id.valid <= 1'b1;

		if (!stall) begin
			if_id.pc_plus4 <= pc_plus4;
			if_id.instr <= instr;
		end
	end

endmodule

// ==== src/memory_stage.sv ====
/*
 * Memory access and writeback.
 * Word-addressed data memory with a combinational read and a write at
 * the edge that ends the MEM cycle, reported on the store port. The
 * MEM/WB register feeds the writeback select, which goes to the
 * register file, the EX forwarding and the retire port.
 */
module memory_stage import mips_pkg::*; #(
	parameter int DMEM_ADDR_BITS = 6
) (
	input  logic    clk,
	input  logic    reset,
	input  ex_mem_t ex_mem,
	output wb_bus_t wb,
	output logic    store,
	output word_t   store_addr,
	output word_t   store_data
);

	word_t   dmem [2**DMEM_ADDR_BITS];
	word_t   load_data;
	mem_wb_t mem_wb;

	assign load_data = dmem[ex_mem.alu_result[DMEM_ADDR_BITS+1:2]];

	always_ff @(posedge clk) begin
		if (ex_mem.mem_ctrl.mem_write)
			dmem[ex_mem.alu_result[DMEM_ADDR_BITS+1:2]] <= ex_mem.store_data;
	end

	assign store = ex_mem.mem_ctrl.mem_write;
	assign store_addr = ex_mem.alu_result;
	assign store_data = ex_mem.store_data;

	// MEM/WB
	always_ff @(posedge clk) begin
		mem_wb.dest <= ex_mem.dest;
		mem_wb.alu_result <= ex_mem.alu_result;
		mem_wb.load_data <= load_data;
		if (reset)
			mem_wb.wb_ctrl <= '0;
		else
			mem_wb.wb_ctrl <= ex_mem.wb_ctrl;
	end

	// writes to register 0 are dropped here
	assign wb.write_en = mem_wb.wb_ctrl.reg_write && mem_wb.dest != '0;
	assign wb.dest = mem_wb.dest;
	assign wb.data = mem_wb.wb_ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== src/mips_core.sv ====
/*
 * Top level of the five-stage MIPS subset core.
 * Connects fetch, decode, execute and memory/writeback through the
 * pipeline-register structs. The program is loaded into instruction
 * memory through the load port while reset is high; every register
 * write shows on the retire port and every data store on the store port.
 */
module mips_core import mips_pkg::*; #(
	parameter int IMEM_ADDR_BITS = 6,
	parameter int DMEM_ADDR_BITS = 6
) (
	input  logic      clk,
	input  logic      reset,

	// program load, byte address, only taken during reset
	input  logic      load,
	input  word_t     load_addr,
	input  word_t     load_data,

	output logic      retire,
	output reg_addr_t retire_reg,
	output word_t     retire_data,

	output logic      store,
	output word_t     store_addr,
	output word_t     store_data
);

	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	wb_bus_t wb;
	logic    stall;
	logic    redirect;
	word_t   target;

	fetch_stage #(
		.IMEM_ADDR_BITS(IMEM_ADDR_BITS)
	) u_fetch_stage (
		.clk(clk),
		.reset(reset),
		.load(load),
		.stall(stall),
		.redirect(redirect),
		.load_addr(load_addr),
		.load_data(load_data),
		.target(target),
		.if_id(if_id)
	);

	decode_stage u_decode_stage (
		.clk(clk),
		.reset(reset),
		.if_id(if_id),
		.wb(wb),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.id_ex(id_ex)
	);

	execute_stage u_execute_stage (
		.clk(clk),
		.reset(reset),
		.id_ex(id_ex),
		.wb(wb),
		.ex_mem(ex_mem)
	);

	memory_stage #(
		.DMEM_ADDR_BITS(DMEM_ADDR_BITS)
	) u_memory_stage (
		.clk(clk),
		.reset(reset),
		.ex_mem(ex_mem),
		.wb(wb),
		.store(store),
		.store_addr(store_addr),
		.store_data(store_data)
	);

	// retire port is the registered writeback
	assign retire      = wb.write_en;
	assign retire_reg  = wb.dest;
	assign retire_data = wb.data;

endmodule

// ==== src/mips_pkg.sv ====
/*
 * Shared types for the five-stage MIPS subset core.
 * Holds the word and field widths, the ISA encodings used by decode
 * and execute, and the packed pipeline-register structs that the
 * stage modules pass between each other.
 */
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] shamt_t;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	// r-type function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL} alu_op_t;

	// coarse class from decode, refined by funct in EX
	typedef enum logic [1:0] {CLASS_ADD, CLASS_SUB, CLASS_FUNCT} alu_class_t;

	typedef struct packed {
		logic  valid;
		word_t pc_plus4;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		alu_class_t alu_class;
		logic       alu_src;
		funct_t     funct;
		shamt_t     shamt;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex_ctrl;
		mem_ctrl_t mem_ctrl;
		wb_ctrl_t  wb_ctrl;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm;
	} id_ex_t;

	typedef struct packed {
		mem_ctrl_t mem_ctrl;
		wb_ctrl_t  wb_ctrl;
		reg_addr_t dest;
		word_t     alu_result;
		word_t     store_data;
	} ex_mem_t;

	typedef struct packed {
		wb_ctrl_t  wb_ctrl;
		reg_addr_t dest;
		word_t     alu_result;
		word_t     load_data;
	} mem_wb_t;

	// writeback as seen by the register file and the EX forwarding
	typedef struct packed {
		logic      write_en;
		reg_addr_t dest;
		word_t     data;
	} wb_bus_t;

endpackage

// ==== tests/tb_programs.svh ====
/*
 * Test programs and expected events for the core testbench.
 * Included inside the testbench module. prog_words holds all programs
 * back to back; each test entry gives the slice of words loaded at
 * address 0 and the slices of the expected retire (register, value)
 * and store (byte address, data) events, checked in order.
 */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS = 5;
localparam int TOTAL_WORDS = 37;
localparam int TOTAL_RETIRES = 23;
localparam int TOTAL_STORES = 1;

typedef struct packed {
	logic [7:0] prog_start;
	logic [7:0] prog_len;
	logic [7:0] ret_start;
	logic [7:0] ret_len;
	logic [7:0] st_start;
	logic [7:0] st_len;
} test_t;

// register number or byte address, then the value
typedef struct packed {
	word_t key;
	word_t value;
} event_t;

// prog_start, prog_len, ret_start, ret_len, st_start, st_len
test_t tests [NUM_TESTS] = '{
	{8'd0, 8'd8, 8'd0, 8'd7, 8'd0, 8'd0},
	{8'd8, 8'd6, 8'd7, 8'd4, 8'd0, 8'd1},
	{8'd14, 8'd10, 8'd11, 8'd5, 8'd1, 8'd0},
	{8'd24, 8'd6, 8'd16, 8'd2, 8'd1, 8'd0},
	{8'd30, 8'd7, 8'd18, 8'd5, 8'd1, 8'd0}
};

word_t prog_words [TOTAL_WORDS] = '{
	// dependent alu chain, forwarding from MEM and WB
	32'h20010005, // addi $1, $0, 5
	32'h20220003, // addi $2, $1, 3
	32'h00411820, // add  $3, $2, $1
	32'h00612022, // sub  $4, $3, $1
	32'h00832824, // and  $5, $4, $3
	32'h00A13025, // or   $6, $5, $1
	32'h0086382A, // slt  $7, $4, $6
	32'h08000007, // j    7
	// store, load, load-use stall
	32'h20010010, // addi $1, $0, 0x10
	32'h20021234, // addi $2, $0, 0x1234
	32'hAC220004, // sw   $2, 4($1)
	32'h8C230004, // lw   $3, 4($1)
	32'h00622020, // add  $4, $3, $2
	32'h08000005, // j    5
	// bne not taken, beq taken
	32'h20010007, // addi $1, $0, 7
	32'h20020007, // addi $2, $0, 7
	32'h20030001, // addi $3, $0, 1
	32'h20040002, // addi $4, $0, 2
	32'h14220002, // bne  $1, $2, +2
	32'h10220002, // beq  $1, $2, +2
	32'h20050055, // addi $5, $0, 0x55
	32'h20060066, // addi $6, $0, 0x66
	32'h20070077, // addi $7, $0, 0x77
	32'h08000009, // j    9
	// jump over two words
	32'h20010001, // addi $1, $0, 1
	32'h08000004, // j    4
	32'h20020002, // addi $2, $0, 2
	32'h20030003, // addi $3, $0, 3
	32'h20240004, // addi $4, $1, 4
	32'h08000005, // j    5
	// register 0, sll, negative slt
	32'h20010021, // addi $1, $0, 0x21
	32'h20000009, // addi $0, $0, 9
	32'h00011020, // add  $2, $0, $1
	32'h00011900, // sll  $3, $1, 4
	32'h2004FFFD, // addi $4, $0, -3
	32'h0081282A, // slt  $5, $4, $1
	32'h08000006  // j    6
};

event_t retire_table [TOTAL_RETIRES] = '{
	{32'd1, 32'd5}, {32'd2, 32'd8}, {32'd3, 32'd13}, {32'd4, 32'd8},
	{32'd5, 32'd8}, {32'd6, 32'd13}, {32'd7, 32'd1},
	{32'd1, 32'h10}, {32'd2, 32'h1234}, {32'd3, 32'h1234}, {32'd4, 32'h2468},
	{32'd1, 32'd7}, {32'd2, 32'd7}, {32'd3, 32'd1}, {32'd4, 32'd2}, {32'd7, 32'h77},
	{32'd1, 32'd1}, {32'd4, 32'd5},
	{32'd1, 32'h21}, {32'd2, 32'h21}, {32'd3, 32'h210},
	{32'd4, 32'hFFFF_FFFD}, {32'd5, 32'd1}
};

event_t store_table [TOTAL_STORES] = '{
	{32'h14, 32'h1234}
};

`endif

// ==== tests/tb_mips_core.sv ====
/*
 * Testbench for the MIPS subset core.
 * For each program in the table it loads the words during reset,
 * releases reset and checks every retire and store event in order
 * against the expected entries. One line per test, then the totals.
 */
module tb_mips_core import mips_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int EVENT_WAIT = 40;
	localparam int TAIL_CYCLES = 10;

	`include "tb_programs.svh"

	logic      clk;
	logic      reset;
	logic      load;
	word_t     load_addr;
	word_t     load_data;
	logic      retire;
	reg_addr_t retire_reg;
	word_t     retire_data;
	logic      store;
	word_t     store_addr;
	word_t     store_data;

	int error_count;
	int check_count;
	int tests_failed;

	mips_core #(
		.IMEM_ADDR_BITS(6),
		.DMEM_ADDR_BITS(6)
	) u_mips_core (
		.clk(clk),
		.reset(reset),
		.load(load),
		.load_addr(load_addr),
		.load_data(load_data),
		.retire(retire),
		.retire_reg(retire_reg),
		.retire_data(retire_data),
		.store(store),
		.store_addr(store_addr),
		.store_data(store_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected) begin
			$display("** Error at time %0t: %s expected %h, got %h",
				$time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic run_test(input int t);
		test_t  tc;
		event_t exp;
		int     i;
		int     ret_seen;
		int     st_seen;
		int     idle;
		int     tail;
		int     errs_before;
		@(negedge clk);
		tc = tests[t];
		errs_before = error_count;
		reset = 1'b1;
		// program goes in at address 0 while reset is high
		for (i = 0; i < tc.prog_len; i++) begin
			load = 1'b1;
			load_addr = i * 4;
			load_data = prog_words[tc.prog_start + i];
			@(negedge clk);
		end
		load = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		ret_seen = 0;
		st_seen = 0;
		idle = 0;
		tail = 0;
		// outputs are registered, stable at the falling edge
		while (idle < EVENT_WAIT && tail < TAIL_CYCLES) begin
			@(negedge clk);
			idle++;
			if (retire) begin
				idle = 0;
				if (ret_seen < tc.ret_len) begin
					exp = retire_table[tc.ret_start + ret_seen];
					check_value("retire_reg", exp.key, {27'b0, retire_reg});
					check_value("retire_data", exp.value, retire_data);
					ret_seen++;
				end else begin
					$display("test %0d: unexpected retire of r%0d = %h at time %0t",
						t, retire_reg, retire_data, $time);
					error_count++;
				end
			end
			if (store) begin
				idle = 0;
				if (st_seen < tc.st_len) begin
					exp = store_table[tc.st_start + st_seen];
					check_value("store_addr", exp.key, store_addr);
					check_value("store_data", exp.value, store_data);
					st_seen++;
				end else begin
					$display("test %0d: unexpected store of %h to %h at time %0t",
						t, store_data, store_addr, $time);
					error_count++;
				end
			end
			// keep watching a while after the last expected event
			if (ret_seen == tc.ret_len && st_seen == tc.st_len)
				tail++;
		end

		if (idle >= EVENT_WAIT) begin
			if (ret_seen < tc.ret_len)
				$display("test %0d: retire %0d of %0d did not come within %0d cycles",
					t, ret_seen + 1, tc.ret_len, EVENT_WAIT);
			else
				$display("test %0d: store %0d of %0d did not come within %0d cycles",
					t, st_seen + 1, tc.st_len, EVENT_WAIT);
			error_count++;
		end

		if (error_count == errs_before) begin
			$display("test %0d passed: %0d retires, %0d stores", t, ret_seen, st_seen);
		end else begin
			$display("test %0d failed: %0d errors", t, error_count - errs_before);
			tests_failed++;
		end
	endtask

	initial begin : main
		int t;
		clk = 1'b0;
		reset = 1'b1;
		load = 1'b0;
		load_addr = '0;
		load_data = '0;
		error_count = 0;
		check_count = 0;
		tests_failed = 0;
		for (t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			NUM_TESTS, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// 60 cycles per program word covers load, reset and run
	initial begin : watchdog
		#(TOTAL_WORDS * 60 * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", TOTAL_WORDS * 60);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
